//--- src/gat_pkg.sv
`default_nettype none

package gat_pkg;

  // ====================================================================
  // Sizes
  // ====================================================================
  localparam int NUM_FEATURE_OUT    = 4;
  localparam int NUM_SUBGRAPHS      = 4;
  localparam int MAX_NODES          = 8;
  localparam int NEW_FEATURE_DEPTH  = NUM_SUBGRAPHS * NUM_FEATURE_OUT;
  localparam int FIFO_DEPTH         = 4;

  // ====================================================================
  // Widths
  // ====================================================================
  // Attention coefficient, unsigned
  localparam int DATA_WIDTH         = 8;
  // Transformed feature lane, signed
  localparam int WH_DATA_WIDTH      = 12;
  // Aggregated output lane, signed
  localparam int NEW_FEATURE_WIDTH  = 32;

  // Must hold MAX_NODES itself
  localparam int NUM_NODE_WIDTH     = $clog2(MAX_NODES + 1);
  localparam int NEW_FEATURE_ADDR_W = $clog2(NEW_FEATURE_DEPTH);
  localparam int CNT_WIDTH          = $clog2(NUM_FEATURE_OUT);

  // FIFO pointer and occupancy widths
  localparam int FIFO_PTR_W         = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_W         = $clog2(FIFO_DEPTH + 1);

  // ====================================================================
  // Enums
  // ====================================================================
  typedef enum logic [1:0] {
    OP_WEIGHTED = 2'd0,
    OP_PLAIN    = 2'd1,
    OP_RELU     = 2'd2
  } aggr_op_e;

  typedef enum logic {
    DEC_IDLE    = 1'b0,
    DEC_COLLECT = 1'b1
  } dec_state_e;

endpackage

`default_nettype wire

//--- src/node_info_decoder.sv
`default_nettype none
`timescale 1ns/100ps

module node_info_decoder (
  input  wire                                                           clk,
  input  wire                                                           rst_n,

  // Subgraph header
  input  wire                                                           hdr_vld,
  input  wire gat_pkg::aggr_op_e                                        hdr_op,
  input  wire [gat_pkg::NUM_NODE_WIDTH-1:0]                             hdr_num_nodes,
  output logic                                                          hdr_rdy,

  // Neighbor stream
  input  wire                                                           nbr_vld,
  input  wire [gat_pkg::DATA_WIDTH-1:0]                                 nbr_alpha,
  input  wire [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::WH_DATA_WIDTH-1:0] nbr_wh,

  input  wire                                                           fifo_full,

  // Beats towards the aggregator
  output logic                                                          beat_vld,
  output logic                                                          beat_first,
  output logic                                                          beat_last,
  output gat_pkg::aggr_op_e                                             beat_op,
  output logic [gat_pkg::DATA_WIDTH-1:0]                                alpha,
  output logic [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::WH_DATA_WIDTH-1:0] wh
);

  import gat_pkg::*;

  dec_state_e                state_q;
  aggr_op_e                  op_q;
  logic [NUM_NODE_WIDTH-1:0] num_q;
  logic [NUM_NODE_WIDTH-1:0] cnt_q;
  logic                      hdr_acc;

  // No new subgraph while one is collecting or the FIFO has no room
  assign hdr_rdy = (state_q == DEC_IDLE) && !fifo_full;
  assign hdr_acc = hdr_vld && hdr_rdy;

  // Stray beats outside a subgraph are dropped here
  assign beat_vld   = nbr_vld && (state_q == DEC_COLLECT);
  assign beat_first = beat_vld && (cnt_q == '0);
  assign beat_last  = beat_vld && ((cnt_q + 1'b1) == num_q);
  assign beat_op    = op_q;
  assign alpha      = nbr_alpha;
  assign wh         = nbr_wh;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= DEC_IDLE;
      op_q    <= OP_WEIGHTED;
      num_q   <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DEC_IDLE: begin
          if (hdr_acc) begin
            op_q    <= hdr_op;
            num_q   <= hdr_num_nodes;
            cnt_q   <= '0;
            state_q <= DEC_COLLECT;
          end
        end
        DEC_COLLECT: begin
          if (beat_last) begin
            cnt_q   <= '0;
            state_q <= DEC_IDLE;
          end else if (beat_vld) begin
            cnt_q   <= cnt_q + 1'b1;
          end
        end
        default: state_q <= DEC_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/attention_aggregator.sv
`default_nettype none
`timescale 1ns/100ps

module attention_aggregator (
  input  wire                                                             clk,
  input  wire                                                             rst_n,

  input  wire                                                             beat_vld,
  input  wire                                                             beat_first,
  input  wire                                                             beat_last,
  input  wire gat_pkg::aggr_op_e                                          beat_op,
  input  wire [gat_pkg::DATA_WIDTH-1:0]                                   alpha,
  input  wire [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::WH_DATA_WIDTH-1:0]  wh,

  output logic [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::NEW_FEATURE_WIDTH-1:0] new_feat,
  output logic                                                            new_feat_vld
);

  import gat_pkg::*;

  // Coefficient with a zero sign bit so the product stays signed
  logic signed [DATA_WIDTH:0]        coef;

  logic signed [NEW_FEATURE_WIDTH-1:0] acc_q [NUM_FEATURE_OUT];
  logic signed [NEW_FEATURE_WIDTH-1:0] prod  [NUM_FEATURE_OUT];
  logic signed [NEW_FEATURE_WIDTH-1:0] sum   [NUM_FEATURE_OUT];
  logic signed [NEW_FEATURE_WIDTH-1:0] res   [NUM_FEATURE_OUT];

  // ====================================================================
  // Coefficient select
  // ====================================================================
  always_comb begin
    case (beat_op)
      OP_WEIGHTED: coef = $signed({1'b0, alpha});
      OP_PLAIN:    coef = 9'sd1;
      OP_RELU:     coef = $signed({1'b0, alpha});
      default:     coef = $signed({1'b0, alpha});
    endcase
  end

  // ====================================================================
  // Per-lane multiply-accumulate and post-processing
  // ====================================================================
  always_comb begin
    for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
      prod[i] = coef * $signed(wh[i]);
      // First beat of a subgraph restarts the sum
      sum[i]  = beat_first ? prod[i] : (acc_q[i] + prod[i]);
      if ((beat_op == OP_RELU) && sum[i][NEW_FEATURE_WIDTH-1]) begin
        res[i] = '0;
      end else begin
        res[i] = sum[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_vld) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        acc_q[i] <= sum[i];
      end
    end
  end

  // Result vector, captured on the last beat
  always_ff @(posedge clk) begin
    if (beat_vld && beat_last) begin
      for (int i = 0; i < NUM_FEATURE_OUT; i++) begin
        new_feat[i] <= res[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      new_feat_vld <= 1'b0;
    end else begin
      new_feat_vld <= beat_vld && beat_last;
    end
  end

endmodule

`default_nettype wire

//--- src/feature_fifo.sv
`default_nettype none
`timescale 1ns/100ps

module feature_fifo (
  input  wire                                                                 clk,
  input  wire                                                                 rst_n,
  input  wire [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::NEW_FEATURE_WIDTH-1:0]  din,
  input  wire                                                                 wr_vld,
  input  wire                                                                 rd_vld,
  output logic [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::NEW_FEATURE_WIDTH-1:0] dout,
  output logic                                                                empty,
  output logic                                                                full
);

  import gat_pkg::*;

  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] mem [FIFO_DEPTH];

  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_CNT_W-1:0] count_q;
  logic                  wr_en;
  logic                  rd_en;

  assign empty = (count_q == '0);
  assign full  = (count_q == FIFO_CNT_W'(FIFO_DEPTH));

  // Pushes to a full FIFO and pops from an empty one are ignored
  assign wr_en = wr_vld && !full;
  assign rd_en = rd_vld && !empty;

  // Head entry, visible without a read
  assign dout = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= din;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/feature_controller.sv
`default_nettype none
`timescale 1ns/100ps

module feature_controller (
  input  wire                                                                clk,
  input  wire                                                                rst_n,

  input  wire [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::NEW_FEATURE_WIDTH-1:0] new_feat,
  input  wire                                                                new_feat_vld,

  output logic                                                               fifo_full,

  // New-feature memory write port
  output logic [gat_pkg::NEW_FEATURE_ADDR_W-1:0]                             feat_bram_addra,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]                              feat_bram_din,
  output logic                                                               feat_bram_ena,

  output logic                                                               new_feat_rdy,
  output logic                                                               gat_ready
);

  import gat_pkg::*;

  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] ff_dout;
  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] vec;
  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] vec_q;
  logic                                              ff_empty;
  logic                                              ff_rd;

  logic [CNT_WIDTH-1:0]          lane_cnt_q;
  logic [CNT_WIDTH-1:0]          lane_sel;
  logic [NEW_FEATURE_ADDR_W-1:0] addr_q;
  logic                          last_lane;

  feature_fifo u_feature_fifo (
    .clk    (clk),
    .rst_n  (rst_n),
    .din    (new_feat),
    .wr_vld (new_feat_vld),
    .rd_vld (ff_rd),
    .dout   (ff_dout),
    .empty  (ff_empty),
    .full   (fifo_full)
  );

  // ====================================================================
  // Pop and lane serialization
  // ====================================================================
  assign ff_rd = (lane_cnt_q == '0) && !ff_empty;

  // Lane 0 of a vector comes straight from the FIFO head
  assign vec = ff_rd ? ff_dout : vec_q;

  assign feat_bram_ena = ff_rd || (lane_cnt_q != '0);
  assign last_lane     = feat_bram_ena && (lane_cnt_q == CNT_WIDTH'(NUM_FEATURE_OUT - 1));

  // Highest lane goes to the lowest address
  assign lane_sel        = CNT_WIDTH'(NUM_FEATURE_OUT - 1) - lane_cnt_q;
  assign feat_bram_din   = vec[lane_sel];
  assign feat_bram_addra = addr_q;

  always_ff @(posedge clk) begin
    if (ff_rd) begin
      vec_q <= ff_dout;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lane_cnt_q <= '0;
      addr_q     <= '0;
    end else if (feat_bram_ena) begin
      addr_q <= addr_q + 1'b1;
      if (last_lane) begin
        lane_cnt_q <= '0;
      end else begin
        lane_cnt_q <= lane_cnt_q + 1'b1;
      end
    end
  end

  // ====================================================================
  // Status
  // ====================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      new_feat_rdy <= 1'b0;
      gat_ready    <= 1'b0;
    end else begin
      new_feat_rdy <= last_lane;
      // Sticky once the final word is in memory
      if (feat_bram_ena && (addr_q == NEW_FEATURE_ADDR_W'(NEW_FEATURE_DEPTH - 1))) begin
        gat_ready <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/feature_bram.sv
`default_nettype none
`timescale 1ns/100ps

module feature_bram (
  input  wire                                     clk,

  // Write port
  input  wire                                     wea,
  input  wire [gat_pkg::NEW_FEATURE_ADDR_W-1:0]   addra,
  input  wire [gat_pkg::NEW_FEATURE_WIDTH-1:0]    dina,

  // Registered read port
  input  wire [gat_pkg::NEW_FEATURE_ADDR_W-1:0]   rd_addr,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]   rd_data
);

  import gat_pkg::*;

  logic [NEW_FEATURE_WIDTH-1:0] mem [NEW_FEATURE_DEPTH];

  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= dina;
    end
  end

  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

//--- src/gat_aggr_top.sv
`default_nettype none
`timescale 1ns/100ps

module gat_aggr_top (
  input  wire                                                            clk,
  input  wire                                                            rst_n,

  // Subgraph header
  input  wire                                                            hdr_vld,
  input  wire gat_pkg::aggr_op_e                                         hdr_op,
  input  wire [gat_pkg::NUM_NODE_WIDTH-1:0]                              hdr_num_nodes,
  output logic                                                           hdr_rdy,

  // Neighbor stream
  input  wire                                                            nbr_vld,
  input  wire [gat_pkg::DATA_WIDTH-1:0]                                  nbr_alpha,
  input  wire [gat_pkg::NUM_FEATURE_OUT-1:0][gat_pkg::WH_DATA_WIDTH-1:0] nbr_wh,

  // Memory read-back
  input  wire [gat_pkg::NEW_FEATURE_ADDR_W-1:0]                          rd_addr,
  output logic [gat_pkg::NEW_FEATURE_WIDTH-1:0]                          rd_data,

  output logic                                                           gat_ready
);

  import gat_pkg::*;

  // Decoder to aggregator
  logic                                        beat_vld;
  logic                                        beat_first;
  logic                                        beat_last;
  aggr_op_e                                    beat_op;
  logic [DATA_WIDTH-1:0]                       alpha;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] wh;

  // Aggregator to controller
  logic [NUM_FEATURE_OUT-1:0][NEW_FEATURE_WIDTH-1:0] new_feat;
  logic                                              new_feat_vld;

  // Controller to memory and decoder
  logic                          fifo_full;
  logic [NEW_FEATURE_ADDR_W-1:0] feat_bram_addra;
  logic [NEW_FEATURE_WIDTH-1:0]  feat_bram_din;
  logic                          feat_bram_ena;
  logic                          new_feat_rdy;

  node_info_decoder u_node_info_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .hdr_vld       (hdr_vld),
    .hdr_op        (hdr_op),
    .hdr_num_nodes (hdr_num_nodes),
    .hdr_rdy       (hdr_rdy),
    .nbr_vld       (nbr_vld),
    .nbr_alpha     (nbr_alpha),
    .nbr_wh        (nbr_wh),
    .fifo_full     (fifo_full),
    .beat_vld      (beat_vld),
    .beat_first    (beat_first),
    .beat_last     (beat_last),
    .beat_op       (beat_op),
    .alpha         (alpha),
    .wh            (wh)
  );

  attention_aggregator u_attention_aggregator (
    .clk          (clk),
    .rst_n        (rst_n),
    .beat_vld     (beat_vld),
    .beat_first   (beat_first),
    .beat_last    (beat_last),
    .beat_op      (beat_op),
    .alpha        (alpha),
    .wh           (wh),
    .new_feat     (new_feat),
    .new_feat_vld (new_feat_vld)
  );

  feature_controller u_feature_controller (
    .clk             (clk),
    .rst_n           (rst_n),
    .new_feat        (new_feat),
    .new_feat_vld    (new_feat_vld),
    .fifo_full       (fifo_full),
    .feat_bram_addra (feat_bram_addra),
    .feat_bram_din   (feat_bram_din),
    .feat_bram_ena   (feat_bram_ena),
    .new_feat_rdy    (new_feat_rdy),
    .gat_ready       (gat_ready)
  );

  feature_bram u_feature_bram (
    .clk     (clk),
    .wea     (feat_bram_ena),
    .addra   (feat_bram_addra),
    .dina    (feat_bram_din),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

//--- tests/clock_gen.sv
`default_nettype none
`timescale 1ns/100ps

module clock_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held low over the first five rising edges
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tests/tb_gat_aggr.sv
`default_nettype none
`timescale 1ns/100ps

module tb_gat_aggr;

  import gat_pkg::*;

  wire clk;
  wire rst_n;

  logic                                          hdr_vld;
  aggr_op_e                                      hdr_op;
  logic [NUM_NODE_WIDTH-1:0]                     hdr_num_nodes;
  logic                                          hdr_rdy;
  logic                                          nbr_vld;
  logic [DATA_WIDTH-1:0]                         nbr_alpha;
  logic [NUM_FEATURE_OUT-1:0][WH_DATA_WIDTH-1:0] nbr_wh;
  logic [NEW_FEATURE_ADDR_W-1:0]                 rd_addr;
  logic [NEW_FEATURE_WIDTH-1:0]                  rd_data;
  logic                                          gat_ready;

  // ====================================================================
  // Stimulus table, one row per subgraph
  // ====================================================================
  aggr_op_e                  row_op    [NUM_SUBGRAPHS];
  int                        row_nodes [NUM_SUBGRAPHS];
  logic [NUM_FEATURE_OUT-1:0] row_neg  [NUM_SUBGRAPHS];
  string                     row_name  [NUM_SUBGRAPHS];

  logic [DATA_WIDTH-1:0]           beat_alpha [NUM_SUBGRAPHS][MAX_NODES];
  logic signed [WH_DATA_WIDTH-1:0] beat_wh    [NUM_SUBGRAPHS][MAX_NODES][NUM_FEATURE_OUT];
  longint                          exp_mem    [NEW_FEATURE_DEPTH];

  int checks;
  int errors;

  clock_gen u_clock_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  gat_aggr_top dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .hdr_vld       (hdr_vld),
    .hdr_op        (hdr_op),
    .hdr_num_nodes (hdr_num_nodes),
    .hdr_rdy       (hdr_rdy),
    .nbr_vld       (nbr_vld),
    .nbr_alpha     (nbr_alpha),
    .nbr_wh        (nbr_wh),
    .rd_addr       (rd_addr),
    .rd_data       (rd_data),
    .gat_ready     (gat_ready)
  );

  task automatic set_row(input int r, input aggr_op_e op, input int nodes,
                         input logic [NUM_FEATURE_OUT-1:0] neg, input string name);
    row_op[r]    = op;
    row_nodes[r] = nodes;
    row_neg[r]   = neg;
    row_name[r]  = name;
  endtask

  task automatic load_table();
    set_row(0, OP_WEIGHTED, 3, 4'b0000, "weighted_3");
    set_row(1, OP_PLAIN, 1, 4'b0000, "plain_1");
    // Lanes 0 and 1 forced negative so the clamp shows
    set_row(2, OP_RELU, MAX_NODES, 4'b0011, "relu_max");
    set_row(3, OP_PLAIN, 5, 4'b0000, "plain_5");
  endtask

  task automatic make_beats();
    int v;
    for (int r = 0; r < NUM_SUBGRAPHS; r++) begin
      for (int b = 0; b < MAX_NODES; b++) begin
        beat_alpha[r][b] = DATA_WIDTH'(1 + ($urandom % 255));
        for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
          if (row_neg[r][l]) begin
            v = -(int'($urandom % 2048) + 1);
          end else begin
            v = int'($urandom % 4096) - 2048;
          end
          beat_wh[r][b][l] = WH_DATA_WIDTH'(v);
        end
      end
    end
  endtask

  // Reference sums; lane 3 lands at the lowest address of its vector
  task automatic compute_expected();
    longint acc;
    longint coef;
    for (int r = 0; r < NUM_SUBGRAPHS; r++) begin
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        acc = 0;
        for (int b = 0; b < row_nodes[r]; b++) begin
          coef = (row_op[r] == OP_PLAIN) ? 64'sd1 : longint'(beat_alpha[r][b]);
          acc  = acc + coef * longint'(beat_wh[r][b][l]);
        end
        if ((row_op[r] == OP_RELU) && (acc < 0)) begin
          acc = 0;
        end
        exp_mem[r * NUM_FEATURE_OUT + (NUM_FEATURE_OUT - 1 - l)] = acc;
      end
    end
  endtask

  task automatic check_value(input string name, input longint expected, input longint actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("Error %s: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  // ====================================================================
  // Waits, each bounded by its own cycle limit
  // ====================================================================
  task automatic wait_for_reset(output bit ok);
    int cycles;
    cycles = 0;
    while (!rst_n && cycles < 20) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = rst_n;
    if (!ok) begin
      errors++;
      $display("Reset was never released");
    end
  endtask

  task automatic wait_for_hdr_rdy(output bit ok);
    int cycles;
    cycles = 0;
    while (!hdr_rdy && cycles < 50) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = hdr_rdy;
    if (!ok) begin
      errors++;
      $display("The DUT never became ready for a new header");
    end
  endtask

  task automatic wait_for_gat_ready(output bit ok);
    int cycles;
    cycles = 0;
    while (!gat_ready && cycles < 100) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = gat_ready;
    if (!ok) begin
      errors++;
      $display("gat_ready did not rise after the last subgraph");
    end
  endtask

  // ====================================================================
  // Drivers, all called 1 ns after a rising edge
  // ====================================================================
  task automatic send_stray_beat();
    nbr_vld   = 1'b1;
    nbr_alpha = DATA_WIDTH'($urandom % 256);
    for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
      nbr_wh[l] = WH_DATA_WIDTH'($urandom % 4096);
    end
    @(posedge clk);
    #1;
    nbr_vld = 1'b0;
  endtask

  task automatic send_subgraph(input int r);
    hdr_vld       = 1'b1;
    hdr_op        = row_op[r];
    hdr_num_nodes = NUM_NODE_WIDTH'(row_nodes[r]);
    @(posedge clk);
    #1;
    hdr_vld = 1'b0;
    for (int b = 0; b < row_nodes[r]; b++) begin
      // Decoder is collecting, so no header may be taken
      check_value({row_name[r], " hdr_rdy"}, 0, longint'(hdr_rdy));
      nbr_vld   = 1'b1;
      nbr_alpha = beat_alpha[r][b];
      for (int l = 0; l < NUM_FEATURE_OUT; l++) begin
        nbr_wh[l] = beat_wh[r][b][l];
      end
      @(posedge clk);
      #1;
    end
    nbr_vld = 1'b0;
    check_value({row_name[r], " gat_ready"}, 0, longint'(gat_ready));
  endtask

  task automatic read_back();
    int r;
    for (int a = 0; a < NEW_FEATURE_DEPTH; a++) begin
      r       = a / NUM_FEATURE_OUT;
      rd_addr = NEW_FEATURE_ADDR_W'(a);
      @(posedge clk);
      #1;
      check_value($sformatf("%s lane %0d", row_name[r], NUM_FEATURE_OUT - 1 - a % NUM_FEATURE_OUT),
                  exp_mem[a], longint'($signed(rd_data)));
    end
  endtask

  initial begin
    bit ok;
    bit aborted;

    checks        = 0;
    errors        = 0;
    aborted       = 1'b0;
    hdr_vld       = 1'b0;
    hdr_op        = OP_WEIGHTED;
    hdr_num_nodes = '0;
    nbr_vld       = 1'b0;
    nbr_alpha     = '0;
    nbr_wh        = '0;
    rd_addr       = '0;

    void'($urandom(21));
    load_table();
    make_beats();
    compute_expected();

    wait_for_reset(ok);
    aborted = !ok;
    if (!aborted) begin
      check_value("reset hdr_rdy", 1, longint'(hdr_rdy));
      check_value("reset gat_ready", 0, longint'(gat_ready));
      // Beat with no subgraph open
      send_stray_beat();
    end

    for (int r = 0; r < NUM_SUBGRAPHS && !aborted; r++) begin
      wait_for_hdr_rdy(ok);
      if (!ok) begin
        aborted = 1'b1;
      end else begin
        send_subgraph(r);
        send_stray_beat();
      end
    end

    if (!aborted) begin
      wait_for_gat_ready(ok);
      if (ok) begin
        read_back();
        check_value("final gat_ready", 1, longint'(gat_ready));
      end
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
src/gat_pkg.sv
src/node_info_decoder.sv
src/attention_aggregator.sv
src/feature_fifo.sv
src/feature_controller.sv
src/feature_bram.sv
src/gat_aggr_top.sv
tests/clock_gen.sv
tests/tb_gat_aggr.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal \
  -f compile.f \
  --top-module tb_gat_aggr \
  -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_gat_aggr > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Pass only when the testbench printed the pass line
if grep -qx "TEST PASS" "$LOG"; then
  exit 0
else
  echo "Pass line not found in $LOG"
  exit 1
fi
